// ==== core_ctrl_pkg.sv ====
package core_ctrl_pkg;

    // datapath width
    localparam int XLEN = 32;

    // ALU operation codes
    localparam int ALU_OP_W = 4;

    localparam logic [ALU_OP_W-1:0] ALU_ADD    = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB    = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND    = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR     = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR    = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_SLT    = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SLL    = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SRL    = 4'd7;
    // operand b straight through, for LUI
    localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 4'd8;

    // result select toward writeback
    localparam logic RES_ALU  = 1'b0;
    localparam logic RES_LINK = 1'b1;

endpackage

// ==== core_top.sv ====
`timescale 1ns/1ps

module core_top import isa_pkg::*, core_ctrl_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic              clk,
    input  logic              reset,
    output logic [XLEN-1:0]   instr_addr,
    input  logic [XLEN-1:0]   instr_data,
    output logic              exit,
    output logic [XLEN-1:0]   gp,
    output logic              retire_valid,
    output logic [XLEN-1:0]   retire_pc,
    output logic [REG_AW-1:0] retire_rd,
    output logic [XLEN-1:0]   retire_data
);

    // fetch to decode
    logic            fd_valid;
    logic [XLEN-1:0] fd_pc;
    logic [XLEN-1:0] fd_instr;

    // decode to execute
    logic                de_valid;
    logic [XLEN-1:0]     de_pc;
    logic [XLEN-1:0]     de_rs1_val;
    logic [XLEN-1:0]     de_rs2_val;
    logic [XLEN-1:0]     de_imm;
    logic [ALU_OP_W-1:0] de_alu_op;
    logic                de_use_imm;
    logic                de_is_branch;
    logic                de_branch_ne;
    logic                de_is_jal;
    logic                de_res_sel;
    logic [REG_AW-1:0]   de_rd;
    logic                de_rf_wen;
    logic                de_is_ecall;

    // execute to result
    logic              ew_valid;
    logic [REG_AW-1:0] ew_rd;
    logic              ew_rf_wen;
    logic [XLEN-1:0]   ew_result;
    logic [XLEN-1:0]   ew_pc;
    logic              ew_is_ecall;

    // pipeline control
    logic            decode_stall;
    logic            redirect;
    logic [XLEN-1:0] redirect_pc;
    logic            halt;

    // register file ports
    logic [REG_AW-1:0] rs1_addr;
    logic [REG_AW-1:0] rs2_addr;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    logic              wen;
    logic [REG_AW-1:0] waddr;
    logic [XLEN-1:0]   wdata;
    logic [XLEN-1:0]   gp_data;

    // port names match the wires above
    fetch_stage #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .*
    );

    decode_stage u_decode (
        .*
    );

    execute_stage u_execute (
        .*
    );

    writeback_stage u_writeback (
        .*,
        .gp_in(gp_data)
    );

    reg_file u_reg_file (
        .*
    );

endmodule

// ==== decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage import isa_pkg::*, core_ctrl_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                fd_valid,
    input  logic [XLEN-1:0]     fd_pc,
    input  logic [XLEN-1:0]     fd_instr,
    input  logic                redirect,
    input  logic                halt,
    output logic [REG_AW-1:0]   rs1_addr,
    output logic [REG_AW-1:0]   rs2_addr,
    input  logic [XLEN-1:0]     rs1_data,
    input  logic [XLEN-1:0]     rs2_data,
    output logic                decode_stall,
    output logic                de_valid,
    output logic [XLEN-1:0]     de_pc,
    output logic [XLEN-1:0]     de_rs1_val,
    output logic [XLEN-1:0]     de_rs2_val,
    output logic [XLEN-1:0]     de_imm,
    output logic [ALU_OP_W-1:0] de_alu_op,
    output logic                de_use_imm,
    output logic                de_is_branch,
    output logic                de_branch_ne,
    output logic                de_is_jal,
    output logic                de_res_sel,
    output logic [REG_AW-1:0]   de_rd,
    output logic                de_rf_wen,
    output logic                de_is_ecall
);

    instr_word_t         iw;
    logic [XLEN-1:0]     imm;
    logic [ALU_OP_W-1:0] alu_op;
    logic                use_imm;
    logic                is_branch;
    logic                is_jal;
    logic                is_ecall;
    logic                rf_wen;
    logic                res_sel;
    logic                uses_rs1;
    logic                uses_rs2;

    // register and immediate arithmetic share the funct3 encoding
    function automatic logic [ALU_OP_W-1:0] alu_from_f3(input logic [2:0] f3,
                                                        input logic sub);
        logic [ALU_OP_W-1:0] op;
        case (f3)
            F3_ADD:  op = sub ? ALU_SUB : ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_XOR:  op = ALU_XOR;
            F3_SRL:  op = ALU_SRL;
            F3_OR:   op = ALU_OR;
            F3_AND:  op = ALU_AND;
            default: op = ALU_ADD;
        endcase
        return op;
    endfunction

    assign iw = fd_instr;

    always_comb begin
        // defaults give an I-type add that writes nothing
        imm       = {{20{iw.i.imm[11]}}, iw.i.imm};
        alu_op    = ALU_ADD;
        use_imm   = 1'b1;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        is_ecall  = 1'b0;
        rf_wen    = 1'b0;
        res_sel   = RES_ALU;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        case (iw.r.opcode)
            OPC_OP: begin
                alu_op   = alu_from_f3(iw.r.funct3, iw.r.funct7 == F7_SUB);
                use_imm  = 1'b0;
                rf_wen   = 1'b1;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            OPC_OP_IMM: begin
                alu_op   = alu_from_f3(iw.i.funct3, 1'b0);
                rf_wen   = 1'b1;
                uses_rs1 = 1'b1;
            end
            OPC_LUI: begin
                imm    = {iw.u.imm31_12, 12'b0};
                alu_op = ALU_PASS_B;
                rf_wen = 1'b1;
            end
            OPC_BRANCH: begin
                imm = {{19{iw.b.imm12}}, iw.b.imm12, iw.b.imm11, iw.b.imm10_5,
                       iw.b.imm4_1, 1'b0};
                use_imm   = 1'b0;
                is_branch = 1'b1;
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
            end
            OPC_JAL: begin
                imm = {{11{iw.j.imm20}}, iw.j.imm20, iw.j.imm19_12, iw.j.imm11,
                       iw.j.imm10_1, 1'b0};
                is_jal  = 1'b1;
                res_sel = RES_LINK;
                rf_wen  = 1'b1;
            end
            OPC_SYSTEM: begin
                is_ecall = (iw.i.funct3 == 3'b000) && (iw.i.imm == 12'd0);
            end
            default: begin
            end
        endcase
    end

    assign rs1_addr = iw.r.rs1;
    assign rs2_addr = iw.r.rs2;

    // producer still in execute, its result lands next cycle through the bypass
    assign decode_stall = fd_valid && de_valid && de_rf_wen && (de_rd != '0) &&
                          ((uses_rs1 && de_rd == rs1_addr) ||
                           (uses_rs2 && de_rd == rs2_addr));

    always_ff @(posedge clk) begin
        if (reset) begin
            de_valid <= 1'b0;
        end else begin
            // bubble on stall, wrong path or halt
            de_valid <= fd_valid && !decode_stall && !redirect && !halt;
        end
    end

    always_ff @(posedge clk) begin
        de_pc        <= fd_pc;
        de_rs1_val   <= rs1_data;
        de_rs2_val   <= rs2_data;
        de_imm       <= imm;
        de_alu_op    <= alu_op;
        de_use_imm   <= use_imm;
        de_is_branch <= is_branch;
        de_branch_ne <= (iw.b.funct3 == F3_BNE);
        de_is_jal    <= is_jal;
        de_res_sel   <= res_sel;
        // rd field of branches is immediate bits
        de_rd        <= rf_wen ? iw.r.rd : '0;
        de_rf_wen    <= rf_wen;
        de_is_ecall  <= is_ecall;
    end

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage import isa_pkg::*, core_ctrl_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                halt,
    input  logic                de_valid,
    input  logic [XLEN-1:0]     de_pc,
    input  logic [XLEN-1:0]     de_rs1_val,
    input  logic [XLEN-1:0]     de_rs2_val,
    input  logic [XLEN-1:0]     de_imm,
    input  logic [ALU_OP_W-1:0] de_alu_op,
    input  logic                de_use_imm,
    input  logic                de_is_branch,
    input  logic                de_branch_ne,
    input  logic                de_is_jal,
    input  logic                de_res_sel,
    input  logic [REG_AW-1:0]   de_rd,
    input  logic                de_rf_wen,
    input  logic                de_is_ecall,
    output logic                redirect,
    output logic [XLEN-1:0]     redirect_pc,
    output logic                ew_valid,
    output logic [REG_AW-1:0]   ew_rd,
    output logic                ew_rf_wen,
    output logic [XLEN-1:0]     ew_result,
    output logic [XLEN-1:0]     ew_pc,
    output logic                ew_is_ecall
);

    localparam int SHAMT_W = $clog2(XLEN);

    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_out;
    logic [XLEN-1:0] result;
    logic            taken;

    assign op_b = de_use_imm ? de_imm : de_rs2_val;

    always_comb begin
        case (de_alu_op)
            ALU_ADD:    alu_out = de_rs1_val + op_b;
            ALU_SUB:    alu_out = de_rs1_val - op_b;
            ALU_AND:    alu_out = de_rs1_val & op_b;
            ALU_OR:     alu_out = de_rs1_val | op_b;
            ALU_XOR:    alu_out = de_rs1_val ^ op_b;
            ALU_SLT:    alu_out = XLEN'($signed(de_rs1_val) < $signed(op_b));
            ALU_SLL:    alu_out = de_rs1_val << op_b[SHAMT_W-1:0];
            ALU_SRL:    alu_out = de_rs1_val >> op_b[SHAMT_W-1:0];
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    // predicted not taken, so any taken transfer is a mispredict
    assign taken = de_is_jal ||
                   (de_is_branch && ((de_rs1_val == de_rs2_val) != de_branch_ne));

    assign redirect    = de_valid && !halt && taken;
    assign redirect_pc = de_pc + de_imm;

    // link value for JAL
    assign result = (de_res_sel == RES_LINK) ? de_pc + XLEN'(4) : alu_out;

    always_ff @(posedge clk) begin
        if (reset) begin
            ew_valid <= 1'b0;
        end else begin
            ew_valid <= de_valid && !halt;
        end
    end

    always_ff @(posedge clk) begin
        ew_rd       <= de_rd;
        ew_rf_wen   <= de_rf_wen;
        ew_result   <= result;
        ew_pc       <= de_pc;
        ew_is_ecall <= de_is_ecall;
    end

endmodule

// ==== fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage import core_ctrl_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            reset,
    output logic [XLEN-1:0] instr_addr,
    input  logic [XLEN-1:0] instr_data,
    input  logic            decode_stall,
    input  logic            redirect,
    input  logic [XLEN-1:0] redirect_pc,
    input  logic            halt,
    output logic            fd_valid,
    output logic [XLEN-1:0] fd_pc,
    output logic [XLEN-1:0] fd_instr
);

    logic [XLEN-1:0] pc;

    // instruction memory answers in the same cycle
    assign instr_addr = pc;

    // pc and valid bit
    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= RESET_PC;
            fd_valid <= 1'b0;
        end else if (halt) begin
            fd_valid <= 1'b0;
        end else if (redirect) begin
            // word fetched this cycle is on the wrong path
            pc       <= redirect_pc;
            fd_valid <= 1'b0;
        end else if (!decode_stall) begin
            pc       <= pc + XLEN'(4);
            fd_valid <= 1'b1;
        end
    end

    // held while decode is stalled
    always_ff @(posedge clk) begin
        if (!decode_stall) begin
            fd_pc    <= pc;
            fd_instr <= instr_data;
        end
    end

endmodule

// ==== flist.f ====
isa_pkg.sv
core_ctrl_pkg.sv
reg_file.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
writeback_stage.sv
core_top.sv
tb_imem.sv
tb_core.sv

// ==== isa_pkg.sv ====
package isa_pkg;

    // base opcodes used by this core
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // funct3 for register and immediate arithmetic
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // funct3 for conditional branches
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    // funct7 that turns ADD into SUB
    localparam logic [6:0] F7_SUB = 7'b0100000;

    localparam int NUM_REGS = 32;
    localparam int REG_AW   = $clog2(NUM_REGS);

    // one instruction word, seen through each encoding format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } instr_word_t;

endpackage

// ==== reg_file.sv ====
`timescale 1ns/1ps

module reg_file import isa_pkg::*, core_ctrl_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic [REG_AW-1:0] rs1_addr,
    input  logic [REG_AW-1:0] rs2_addr,
    output logic [XLEN-1:0]   rs1_data,
    output logic [XLEN-1:0]   rs2_data,
    input  logic              wen,
    input  logic [REG_AW-1:0] waddr,
    input  logic [XLEN-1:0]   wdata,
    output logic [XLEN-1:0]   gp_data
);

    localparam logic [REG_AW-1:0] GP_REG = 3;

    // x0 has no storage
    logic [XLEN-1:0] regs [1:NUM_REGS-1];

    // a write in the same cycle wins over the stored value
    function automatic logic [XLEN-1:0] read_port(input logic [REG_AW-1:0] addr);
        logic [XLEN-1:0] val;
        if (addr == '0) begin
            val = '0;
        end else if (wen && waddr == addr) begin
            val = wdata;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
        gp_data  = read_port(GP_REG);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 1; k < NUM_REGS; k++) begin
                regs[k] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_core -f flist.f \
    > sim.log 2>&1 \
    && ./obj_dir/Vtb_core >> sim.log 2>&1 \
    || echo "Test failed" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0

// ==== tb_core.sv ====
`timescale 1ns/1ps

module tb_core import isa_pkg::*; ();

    localparam logic [31:0] RESET_PC = 32'd0;
    localparam int MAX_EXP      = 64;
    localparam int EXIT_TIMEOUT = 400;

    logic        clk;
    logic        reset;
    logic [31:0] instr_addr;
    logic [31:0] instr_data;
    logic        exit;
    logic [31:0] gp;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;

    // expected retire trace, in program order
    logic [31:0] exp_pc   [0:MAX_EXP-1];
    logic [4:0]  exp_rd   [0:MAX_EXP-1];
    logic [31:0] exp_data [0:MAX_EXP-1];
    string       exp_name [0:MAX_EXP-1];
    logic [31:0] exp_gp;
    int          num_exp  = 0;
    int          ret_idx  = 0;
    int          errors   = 0;
    logic [1:0]  rst_hist = 2'b11;
    logic        exit_seen = 1'b0;

    core_top #(
        .RESET_PC(RESET_PC)
    ) dut0 (
        .clk(clk), .reset(reset), .instr_addr(instr_addr), .instr_data(instr_data),
        .exit(exit), .gp(gp), .retire_valid(retire_valid), .retire_pc(retire_pc),
        .retire_rd(retire_rd), .retire_data(retire_data)
    );

    tb_imem imem0 (
        .addr(instr_addr),
        .data(instr_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] isa_alu(input logic [2:0] f3, input logic sub,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            F3_ADD:  r = sub ? a - b : a + b;
            F3_SLL:  r = a << b[4:0];
            F3_SLT:  r = {31'd0, $signed(a) < $signed(b)};
            F3_XOR:  r = a ^ b;
            F3_SRL:  r = a >> b[4:0];
            F3_OR:   r = a | b;
            F3_AND:  r = a & b;
            default: r = '0;
        endcase
        return r;
    endfunction

    // one instruction at a time, no pipeline
    task automatic run_reference_model();
        instr_word_t iw;
        logic [31:0] regs [0:31];
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] val;
        logic        writes;
        logic        done;
        string       name;
        for (int k = 0; k < 32; k++) begin
            regs[k] = '0;
        end
        pc = RESET_PC;
        done = 1'b0;
        while (!done && num_exp < MAX_EXP) begin
            iw = imem0.mem[pc[7:2]];
            a = regs[iw.r.rs1];
            b = regs[iw.r.rs2];
            val = '0;
            writes = 1'b1;
            next_pc = pc + 32'd4;
            case (iw.r.opcode)
                OPC_OP: begin
                    val = isa_alu(iw.r.funct3, iw.r.funct7 == F7_SUB, a, b);
                    name = "reg ALU";
                end
                OPC_OP_IMM: begin
                    val = isa_alu(iw.i.funct3, 1'b0, a, {{20{iw.i.imm[11]}}, iw.i.imm});
                    name = "ADDI";
                end
                OPC_LUI: begin
                    val = {iw.u.imm31_12, 12'd0};
                    name = "LUI";
                end
                OPC_BRANCH: begin
                    writes = 1'b0;
                    name = "branch";
                    if ((a == b) != (iw.b.funct3 == F3_BNE)) begin
                        next_pc = pc + {{19{iw.b.imm12}}, iw.b.imm12, iw.b.imm11,
                                        iw.b.imm10_5, iw.b.imm4_1, 1'b0};
                    end
                end
                OPC_JAL: begin
                    val = pc + 32'd4;
                    name = "JAL";
                    next_pc = pc + {{11{iw.j.imm20}}, iw.j.imm20, iw.j.imm19_12, iw.j.imm11,
                                    iw.j.imm10_1, 1'b0};
                end
                default: begin
                    writes = 1'b0;
                    done = 1'b1;
                    name = "ECALL";
                end
            endcase
            exp_pc[num_exp]   = pc;
            exp_rd[num_exp]   = writes ? iw.r.rd : 5'd0;
            exp_data[num_exp] = writes ? val : 32'd0;
            exp_name[num_exp] = name;
            if (writes && iw.r.rd != 5'd0) begin
                regs[iw.r.rd] = val;
            end
            num_exp++;
            pc = next_pc;
        end
        exp_gp = regs[3];
    endtask

    always @(posedge clk) begin
        rst_hist <= {rst_hist[0], reset};
        if (reset) begin
            ret_idx   <= 0;
            exit_seen <= 1'b0;
        end else begin
            if (retire_valid) begin
                ret_idx <= ret_idx + 1;
            end
            if (exit) begin
                exit_seen <= 1'b1;
            end
        end
    end

    // checks sample at the falling edge, away from DUT updates
    reset_quiet: assert property (@(negedge clk)
        (reset || rst_hist != 2'b00) |-> (!exit && !retire_valid))
        else begin
            errors++;
            $display("exit or retire_valid was high during or right after reset");
        end

    retire_pc_ok: assert property (@(negedge clk) disable iff (reset)
        (retire_valid && ret_idx < num_exp) |-> retire_pc == exp_pc[ret_idx])
        else begin
            errors++;
            $display("Mismatch %s retire_pc: expected %h, actual %h",
                     exp_name[ret_idx], exp_pc[ret_idx], retire_pc);
        end

    retire_rd_ok: assert property (@(negedge clk) disable iff (reset)
        (retire_valid && ret_idx < num_exp) |-> retire_rd == exp_rd[ret_idx])
        else begin
            errors++;
            $display("Mismatch %s at pc %h retire_rd: expected %0d, actual %0d",
                     exp_name[ret_idx], exp_pc[ret_idx], exp_rd[ret_idx], retire_rd);
        end

    retire_data_ok: assert property (@(negedge clk) disable iff (reset)
        (retire_valid && ret_idx < num_exp) |-> retire_data == exp_data[ret_idx])
        else begin
            errors++;
            $display("Mismatch %s at pc %h retire_data: expected %h, actual %h",
                     exp_name[ret_idx], exp_pc[ret_idx], exp_data[ret_idx], retire_data);
        end

    no_extra_retire: assert property (@(negedge clk) disable iff (reset)
        retire_valid |-> ret_idx < num_exp)
        else begin
            errors++;
            $display("more instructions retired than the program allows");
        end

    exit_sticky: assert property (@(negedge clk) disable iff (reset) exit_seen |-> exit)
        else begin
            errors++;
            $display("exit dropped after it had been raised");
        end

    gp_ok: assert property (@(negedge clk) disable iff (reset) exit |-> gp == exp_gp)
        else begin
            errors++;
            $display("Mismatch gp after exit: expected %h, actual %h", exp_gp, gp);
        end

    quiet_after_exit: assert property (@(negedge clk) disable iff (reset)
        exit |-> !retire_valid)
        else begin
            errors++;
            $display("an instruction retired after exit was raised");
        end

    all_retired: assert property (@(negedge clk) disable iff (reset)
        exit |-> ret_idx == num_exp)
        else begin
            errors++;
            $display("exit raised after %0d of %0d retirements", ret_idx, num_exp);
        end

    initial begin
        int cycles;
        reset = 1'b1;
        for (int k = 0; k < 3; k++) begin
            @(posedge clk);
        end
        run_reference_model();
        reset <= 1'b0;
        cycles = 0;
        while (!exit && cycles < EXIT_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (!exit) begin
            errors++;
            $display("timeout, exit did not rise within %0d cycles", EXIT_TIMEOUT);
        end else begin
            // watch the halted core for a few more cycles
            for (int k = 0; k < 8; k++) begin
                @(posedge clk);
            end
        end
        $display("errors %0d, retired %0d of %0d expected", errors, ret_idx, num_exp);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== tb_imem.sv ====
`timescale 1ns/1ps

module tb_imem import isa_pkg::*; (
    input  logic [31:0] addr,
    output logic [31:0] data
);

    localparam int DEPTH = 64;

    logic [31:0] mem [0:DEPTH-1];
    int          seed;

    assign data = mem[addr[7:2]];

    function automatic logic [31:0] reg_op(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        instr_word_t w;
        w.r = {f7, rs2, rs1, f3, rd, OPC_OP};
        return w;
    endfunction

    function automatic logic [31:0] imm_op(input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [11:0] imm);
        instr_word_t w;
        w.i = {imm, rs1, f3, rd, OPC_OP_IMM};
        return w;
    endfunction

    function automatic logic [31:0] upper_imm(input logic [4:0] rd, input logic [19:0] imm);
        instr_word_t w;
        w.u = {imm, rd, OPC_LUI};
        return w;
    endfunction

    // offsets are byte offsets, bit 0 dropped by the format
    function automatic logic [31:0] cond_branch(input logic [2:0] f3, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input logic [12:0] off);
        instr_word_t w;
        w.b = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
        return w;
    endfunction

    function automatic logic [31:0] jump_link(input logic [4:0] rd, input logic [20:0] off);
        instr_word_t w;
        w.j = {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
        return w;
    endfunction

    initial begin
        seed = 23023;
        // nop whose immediate is its own word index
        for (int k = 0; k < DEPTH; k++) begin
            mem[k] = imm_op(F3_ADD, 5'd0, 5'd0, 12'(k));
        end
        mem[0]  = imm_op(F3_ADD, 5'd1, 5'd0, 12'($random(seed)));
        mem[1]  = imm_op(F3_ADD, 5'd2, 5'd0, 12'($random(seed)));
        // back-to-back dependences make decode stall
        mem[2]  = reg_op(7'd0, 5'd2, 5'd1, F3_ADD, 5'd3);
        mem[3]  = reg_op(F7_SUB, 5'd1, 5'd3, F3_ADD, 5'd4);
        mem[4]  = reg_op(7'd0, 5'd2, 5'd1, F3_AND, 5'd5);
        mem[5]  = reg_op(7'd0, 5'd2, 5'd1, F3_OR, 5'd6);
        mem[6]  = reg_op(7'd0, 5'd2, 5'd4, F3_XOR, 5'd7);
        mem[7]  = reg_op(7'd0, 5'd2, 5'd1, F3_SLT, 5'd8);
        mem[8]  = reg_op(7'd0, 5'd2, 5'd1, F3_SLL, 5'd9);
        mem[9]  = reg_op(7'd0, 5'd2, 5'd9, F3_SRL, 5'd10);
        mem[10] = upper_imm(5'd11, 20'($random(seed)));
        mem[11] = imm_op(F3_ADD, 5'd11, 5'd11, 12'($random(seed)));
        // taken beq skips one word, the bne after it falls through
        mem[12] = cond_branch(F3_BEQ, 5'd1, 5'd1, 13'd8);
        mem[13] = imm_op(F3_ADD, 5'd12, 5'd0, 12'd1);
        mem[14] = cond_branch(F3_BNE, 5'd1, 5'd1, 13'd8);
        mem[15] = imm_op(F3_ADD, 5'd12, 5'd12, 12'd5);
        mem[16] = cond_branch(F3_BNE, 5'd12, 5'd0, 13'd12);
        mem[17] = imm_op(F3_ADD, 5'd13, 5'd0, 12'd7);
        mem[18] = imm_op(F3_ADD, 5'd13, 5'd0, 12'd9);
        mem[19] = jump_link(5'd14, 21'd12);
        mem[20] = imm_op(F3_ADD, 5'd15, 5'd0, 12'd1);
        mem[21] = imm_op(F3_ADD, 5'd15, 5'd0, 12'd2);
        // gp collects the link value and one more random step
        mem[22] = reg_op(7'd0, 5'd14, 5'd3, F3_ADD, 5'd3);
        mem[23] = imm_op(F3_ADD, 5'd3, 5'd3, 12'($random(seed)));
        mem[24] = {25'd0, OPC_SYSTEM};
        mem[25] = imm_op(F3_ADD, 5'd16, 5'd0, 12'd3);
    end

endmodule

// ==== writeback_stage.sv ====
`timescale 1ns/1ps

module writeback_stage import isa_pkg::*, core_ctrl_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              ew_valid,
    input  logic [REG_AW-1:0] ew_rd,
    input  logic              ew_rf_wen,
    input  logic [XLEN-1:0]   ew_result,
    input  logic [XLEN-1:0]   ew_pc,
    input  logic              ew_is_ecall,
    output logic              wen,
    output logic [REG_AW-1:0] waddr,
    output logic [XLEN-1:0]   wdata,
    output logic              halt,
    output logic              exit,
    input  logic [XLEN-1:0]   gp_in,
    output logic [XLEN-1:0]   gp,
    output logic              retire_valid,
    output logic [XLEN-1:0]   retire_pc,
    output logic [REG_AW-1:0] retire_rd,
    output logic [XLEN-1:0]   retire_data
);

    // anything behind a retired ECALL is dropped here
    assign wen   = ew_valid && ew_rf_wen && !exit;
    assign waddr = ew_rd;
    assign wdata = ew_result;

    assign retire_valid = ew_valid && !exit;
    assign retire_pc    = ew_pc;
    assign retire_rd    = ew_rd;
    // zero for instructions that write no register
    assign retire_data  = ew_rf_wen ? ew_result : '0;

    // sticky until reset
    always_ff @(posedge clk) begin
        if (reset) begin
            exit <= 1'b0;
        end else if (ew_valid && ew_is_ecall) begin
            exit <= 1'b1;
        end
    end

    assign halt = exit;
    assign gp   = gp_in;

endmodule
